// ==== logic/lstm_pkg.sv ====
package lstm_pkg;

    localparam int data_width = 8;
    localparam int acc_width  = 32;
    localparam int vec_len    = 4;
    localparam int step_width = 4;

    typedef logic signed [data_width-1:0] data_t;
    typedef logic signed [acc_width-1:0]  acc_t;
    typedef logic [step_width-1:0]        step_t;

    // element 0 sits in the low byte
    typedef data_t [vec_len-1:0] vec_t;

    typedef struct packed {
        vec_t w;
        vec_t r;
    } gate_weights_t;

    typedef enum logic [2:0] {
        sel_i,
        sel_z,
        sel_f,
        sel_o,
        sel_c
    } lookup_sel_e;

    typedef struct packed {
        logic        req;
        lookup_sel_e sel;
        data_t       arg;
    } lookup_req_t;

    localparam acc_t data_max = acc_t'((1 <<< (data_width - 1)) - 1);
    localparam acc_t data_min = -acc_t'(1 <<< (data_width - 1));

    // clamp a wide value into one data element
    function automatic data_t sat_data(input acc_t v);
        data_t res;
        if (v > data_max) begin
            res = data_t'(data_max);
        end else if (v < data_min) begin
            res = data_t'(data_min);
        end else begin
            res = v[data_width-1:0];
        end
        return res;
    endfunction

endpackage

// ==== logic/cell_sequencer.sv ====
`timescale 1ns/1ns

module cell_sequencer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    output logic            load,
    output logic            busy,
    output lstm_pkg::step_t step
);

    typedef enum logic {
        seq_idle,
        seq_busy
    } seq_state_e;

    localparam lstm_pkg::step_t last_step = 4'd9;
    // no module decodes this code, so idle cycles stay quiet
    localparam lstm_pkg::step_t idle_step = 4'd15;

    seq_state_e      state;
    lstm_pkg::step_t count;

    assign busy = (state == seq_busy);
    assign load = start && (state == seq_idle);
    assign step = busy ? count : idle_step;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= seq_idle;
            count <= '0;
        end else begin
            case (state)
                seq_idle: begin
                    count <= '0;
                    if (load) begin
                        state <= seq_busy;
                    end
                end
                seq_busy: begin
                    if (count == last_step) begin
                        // wrap and fall back to idle at E10
                        count <= '0;
                        state <= seq_idle;
                    end else begin
                        count <= count + 4'd1;
                    end
                end
                default: begin
                    state <= seq_idle;
                    count <= '0;
                end
            endcase
        end
    end

endmodule

// ==== logic/gate_dot.sv ====
`timescale 1ns/1ns

module gate_dot (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load,
    input  lstm_pkg::step_t         step,
    input  lstm_pkg::vec_t          x,
    input  lstm_pkg::vec_t          y_prev,
    input  lstm_pkg::gate_weights_t weights,
    output lstm_pkg::acc_t          pre
);

    localparam int half = lstm_pkg::vec_len / 2;

    lstm_pkg::vec_t          x_q;
    lstm_pkg::vec_t          y_q;
    lstm_pkg::gate_weights_t wt_q;

    lstm_pkg::acc_t prod_w [lstm_pkg::vec_len];
    lstm_pkg::acc_t prod_r [lstm_pkg::vec_len];
    lstm_pkg::acc_t pair_w [half];
    lstm_pkg::acc_t pair_r [half];
    lstm_pkg::acc_t pre_sum;

    // operands held for the whole run
    always_ff @(posedge clk) begin
        if (load) begin
            x_q  <= x;
            y_q  <= y_prev;
            wt_q <= weights;
        end
    end

    always_ff @(posedge clk) begin
        if (step == 4'd0) begin
            for (int k = 0; k < lstm_pkg::vec_len; k++) begin
                prod_w[k] <= wt_q.w[k] * x_q[k];
                prod_r[k] <= wt_q.r[k] * y_q[k];
            end
        end
        if (step == 4'd1) begin
            for (int p = 0; p < half; p++) begin
                pair_w[p] <= prod_w[2*p] + prod_w[2*p+1];
                pair_r[p] <= prod_r[2*p] + prod_r[2*p+1];
            end
        end
    end

    always_comb begin
        pre_sum = '0;
        for (int p = 0; p < half; p++) begin
            pre_sum = pre_sum + pair_w[p] + pair_r[p];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre <= '0;
        end else if (step == 4'd2) begin
            pre <= pre_sum;
        end
    end

endmodule

// ==== logic/activation_port.sv ====
`timescale 1ns/1ns

module activation_port #(
    parameter int PRE_SHIFT = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lstm_pkg::step_t       step,
    input  lstm_pkg::acc_t        pre_i,
    input  lstm_pkg::acc_t        pre_z,
    input  lstm_pkg::acc_t        pre_f,
    input  lstm_pkg::acc_t        pre_o,
    input  lstm_pkg::data_t       c_state,
    input  lstm_pkg::data_t       act_result,
    output lstm_pkg::lookup_req_t act_req,
    output lstm_pkg::data_t       act_i,
    output lstm_pkg::data_t       act_z,
    output lstm_pkg::data_t       act_f,
    output lstm_pkg::data_t       act_o,
    output lstm_pkg::data_t       act_c
);

    localparam lstm_pkg::step_t step_i = 4'd3;
    localparam lstm_pkg::step_t step_z = 4'd4;
    localparam lstm_pkg::step_t step_f = 4'd5;
    localparam lstm_pkg::step_t step_o = 4'd6;
    localparam lstm_pkg::step_t step_c = 4'd8;

    lstm_pkg::acc_t gate_pre;

    // one lookup lane shared over five steps
    always_comb begin
        act_req     = '0;
        act_req.sel = lstm_pkg::sel_i;
        gate_pre    = '0;
        case (step)
            step_i: begin
                act_req.req = 1'b1;
                act_req.sel = lstm_pkg::sel_i;
                gate_pre    = pre_i;
            end
            step_z: begin
                act_req.req = 1'b1;
                act_req.sel = lstm_pkg::sel_z;
                gate_pre    = pre_z;
            end
            step_f: begin
                act_req.req = 1'b1;
                act_req.sel = lstm_pkg::sel_f;
                gate_pre    = pre_f;
            end
            step_o: begin
                act_req.req = 1'b1;
                act_req.sel = lstm_pkg::sel_o;
                gate_pre    = pre_o;
            end
            step_c: begin
                act_req.req = 1'b1;
                act_req.sel = lstm_pkg::sel_c;
            end
            default: begin
                act_req.req = 1'b0;
            end
        endcase
        // c is already a data element, gates need scaling first
        if (act_req.sel == lstm_pkg::sel_c) begin
            act_req.arg = c_state;
        end else begin
            act_req.arg = lstm_pkg::sat_data(gate_pre >>> PRE_SHIFT);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_i <= '0;
            act_z <= '0;
            act_f <= '0;
            act_o <= '0;
            act_c <= '0;
        end else if (act_req.req) begin
            case (act_req.sel)
                lstm_pkg::sel_i: act_i <= act_result;
                lstm_pkg::sel_z: act_z <= act_result;
                lstm_pkg::sel_f: act_f <= act_result;
                lstm_pkg::sel_o: act_o <= act_result;
                default:         act_c <= act_result;
            endcase
        end
    end

endmodule

// ==== logic/cell_update.sv ====
`timescale 1ns/1ns

module cell_update #(
    parameter int FRAC_BITS = 7
) (
    input  logic            clk,
    input  logic            rst_n,
    input  lstm_pkg::step_t step,
    input  lstm_pkg::data_t act_i,
    input  lstm_pkg::data_t act_z,
    input  lstm_pkg::data_t act_f,
    input  lstm_pkg::data_t act_o,
    input  lstm_pkg::data_t act_c,
    output lstm_pkg::data_t c_state,
    output lstm_pkg::data_t y,
    output logic            valid
);

    localparam lstm_pkg::step_t step_cell = 4'd7;
    localparam lstm_pkg::step_t step_out  = 4'd9;

    lstm_pkg::acc_t c_mix;
    lstm_pkg::acc_t y_mix;
    lstm_pkg::acc_t c_prod_f;
    lstm_pkg::acc_t c_prod_i;

    // forget path keeps old c, input path adds the candidate
    assign c_prod_f = act_f * c_state;
    assign c_prod_i = act_i * act_z;
    assign c_mix    = c_prod_f + c_prod_i;
    assign y_mix    = act_o * act_c;

    // carried across runs, so only reset clears it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c_state <= '0;
        end else if (step == step_cell) begin
            c_state <= lstm_pkg::sat_data(c_mix >>> FRAC_BITS);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y     <= '0;
            valid <= 1'b0;
        end else begin
            // single cycle strobe after the last step
            valid <= (step == step_out);
            if (step == step_out) begin
                y <= lstm_pkg::sat_data(y_mix >>> FRAC_BITS);
            end
        end
    end

endmodule

// ==== logic/lstm_cell_top.sv ====
`timescale 1ns/1ns

module lstm_cell_top #(
    parameter int PRE_SHIFT = 8,
    parameter int FRAC_BITS = 7
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  lstm_pkg::vec_t          x,
    input  lstm_pkg::vec_t          y_prev,
    input  lstm_pkg::gate_weights_t w_i,
    input  lstm_pkg::gate_weights_t w_z,
    input  lstm_pkg::gate_weights_t w_f,
    input  lstm_pkg::gate_weights_t w_o,
    input  lstm_pkg::data_t         act_result,
    output lstm_pkg::lookup_req_t   act_req,
    output lstm_pkg::data_t         y,
    output logic                    valid
);

    logic            load;
    lstm_pkg::step_t step;
    lstm_pkg::acc_t  pre_i;
    lstm_pkg::acc_t  pre_z;
    lstm_pkg::acc_t  pre_f;
    lstm_pkg::acc_t  pre_o;
    lstm_pkg::data_t c_state;
    lstm_pkg::data_t act_i;
    lstm_pkg::data_t act_z;
    lstm_pkg::data_t act_f;
    lstm_pkg::data_t act_o;
    lstm_pkg::data_t act_c;

    cell_sequencer i_cell_sequencer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .load  (load),
        .busy  (),
        .step  (step)
    );

    gate_dot gate_dot_i (
        .clk(clk), .rst_n(rst_n), .load(load), .step(step),
        .x(x), .y_prev(y_prev), .weights(w_i), .pre(pre_i)
    );
    gate_dot gate_dot_z (
        .clk(clk), .rst_n(rst_n), .load(load), .step(step),
        .x(x), .y_prev(y_prev), .weights(w_z), .pre(pre_z)
    );
    gate_dot gate_dot_f (
        .clk(clk), .rst_n(rst_n), .load(load), .step(step),
        .x(x), .y_prev(y_prev), .weights(w_f), .pre(pre_f)
    );
    gate_dot gate_dot_o (
        .clk(clk), .rst_n(rst_n), .load(load), .step(step),
        .x(x), .y_prev(y_prev), .weights(w_o), .pre(pre_o)
    );

    activation_port #(
        .PRE_SHIFT(PRE_SHIFT)
    ) i_activation_port (
        .clk(clk), .rst_n(rst_n), .step(step),
        .pre_i(pre_i), .pre_z(pre_z), .pre_f(pre_f), .pre_o(pre_o),
        .c_state(c_state), .act_result(act_result), .act_req(act_req),
        .act_i(act_i), .act_z(act_z), .act_f(act_f), .act_o(act_o), .act_c(act_c)
    );

    cell_update #(
        .FRAC_BITS(FRAC_BITS)
    ) i_cell_update (
        .clk(clk), .rst_n(rst_n), .step(step),
        .act_i(act_i), .act_z(act_z), .act_f(act_f), .act_o(act_o), .act_c(act_c),
        .c_state(c_state), .y(y), .valid(valid)
    );

endmodule

// ==== include/lstm_cell_model.svh ====
`ifndef LSTM_CELL_MODEL_SVH
`define LSTM_CELL_MODEL_SVH

// fibonacci form, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// clamp to the signed byte range
function automatic lstm_pkg::data_t clamp_data(input longint v);
    lstm_pkg::data_t res;
    if (v > 127) begin
        res = lstm_pkg::data_t'(127);
    end else if (v < -128) begin
        res = lstm_pkg::data_t'(-128);
    end else begin
        res = lstm_pkg::data_t'(v);
    end
    return res;
endfunction

function automatic lstm_pkg::acc_t model_pre(input lstm_pkg::vec_t x,
                                             input lstm_pkg::vec_t y_prev,
                                             input lstm_pkg::gate_weights_t g);
    lstm_pkg::acc_t sum;
    sum = '0;
    for (int k = 0; k < lstm_pkg::vec_len; k++) begin
        sum = sum + lstm_pkg::acc_t'(g.w[k]) * lstm_pkg::acc_t'(x[k])
                  + lstm_pkg::acc_t'(g.r[k]) * lstm_pkg::acc_t'(y_prev[k]);
    end
    return sum;
endfunction

function automatic lstm_pkg::data_t model_gate_arg(input lstm_pkg::acc_t pre, input int shift);
    return clamp_data(pre >>> shift);
endfunction

// responder rule: half the argument, offset by 32
function automatic lstm_pkg::data_t model_respond(input lstm_pkg::data_t arg);
    lstm_pkg::acc_t wide;
    wide = lstm_pkg::acc_t'(arg);
    return clamp_data((wide >>> 1) + 32);
endfunction

function automatic lstm_pkg::data_t model_cell(input lstm_pkg::data_t act_f,
                                               input lstm_pkg::data_t c,
                                               input lstm_pkg::data_t act_i,
                                               input lstm_pkg::data_t act_z,
                                               input int frac);
    lstm_pkg::acc_t mix;
    mix = lstm_pkg::acc_t'(act_f) * lstm_pkg::acc_t'(c)
        + lstm_pkg::acc_t'(act_i) * lstm_pkg::acc_t'(act_z);
    return clamp_data(mix >>> frac);
endfunction

function automatic lstm_pkg::data_t model_y(input lstm_pkg::data_t act_o,
                                            input lstm_pkg::data_t act_c,
                                            input int frac);
    lstm_pkg::acc_t prod;
    prod = lstm_pkg::acc_t'(act_o) * lstm_pkg::acc_t'(act_c);
    return clamp_data(prod >>> frac);
endfunction

`endif

// ==== bench/lstm_cell_tb.sv ====
`timescale 1ns/1ns

module lstm_cell_tb;

    localparam int pre_shift    = 8;
    localparam int frac_bits    = 7;
    localparam int period       = 4;
    localparam int reset_cycles = 16;
    localparam int n_rows       = 8;
    localparam int n_fixed      = 5;
    localparam int idle_checks  = 3;

    `include "lstm_cell_model.svh"

    typedef struct packed {
        lstm_pkg::vec_t          x;
        lstm_pkg::vec_t          y_prev;
        lstm_pkg::gate_weights_t w_i;
        lstm_pkg::gate_weights_t w_z;
        lstm_pkg::gate_weights_t w_f;
        lstm_pkg::gate_weights_t w_o;
        logic                    change_in;
    } row_t;

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    lstm_pkg::vec_t          x;
    lstm_pkg::vec_t          y_prev;
    lstm_pkg::gate_weights_t w_i;
    lstm_pkg::gate_weights_t w_z;
    lstm_pkg::gate_weights_t w_f;
    lstm_pkg::gate_weights_t w_o;
    lstm_pkg::data_t         act_result;
    lstm_pkg::lookup_req_t   act_req;
    lstm_pkg::data_t         y;
    logic                    valid;

    row_t            rows [n_rows];
    string           names [n_rows];
    logic [31:0]     lfsr_state;
    lstm_pkg::data_t c_model;
    lstm_pkg::data_t last_y;

    lstm_cell_top #(
        .PRE_SHIFT(pre_shift),
        .FRAC_BITS(frac_bits)
    ) i_lstm_cell_top (
        .clk(clk), .rst_n(rst_n), .start(start), .x(x), .y_prev(y_prev),
        .w_i(w_i), .w_z(w_z), .w_f(w_f), .w_o(w_o), .act_result(act_result),
        .act_req(act_req), .y(y), .valid(valid)
    );

    // outside activation table, answers in the same cycle
    assign act_result = model_respond(act_req.arg);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        #((reset_cycles + 4 + n_rows * 20) * period);
        $display("timeout: valid never arrived within the allowed cycles");
        $display("Errors found");
        $fatal(1);
    end

    task automatic check(input string name, input logic signed [31:0] expected,
                         input logic signed [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic lstm_pkg::vec_t rand_vec();
        lstm_pkg::vec_t v;
        logic [31:0]    b;
        for (int k = 0; k < lstm_pkg::vec_len; k++) begin
            b = rand_bits(8);
            v[k] = b[7:0];
        end
        return v;
    endfunction

    function automatic lstm_pkg::vec_t fill_vec(input int a);
        lstm_pkg::vec_t v;
        for (int k = 0; k < lstm_pkg::vec_len; k++) begin
            v[k] = lstm_pkg::data_t'(a);
        end
        return v;
    endfunction

    function automatic lstm_pkg::gate_weights_t gate_fill(input int w, input int r);
        lstm_pkg::gate_weights_t g;
        g.w = fill_vec(w);
        g.r = fill_vec(r);
        return g;
    endfunction

    task automatic build_table();
        logic [31:0] b;
        // repeat pair shows the carried c, then saturation rows
        rows[0] = {fill_vec(16), fill_vec(0), gate_fill(32, 0), gate_fill(64, 0),
                   gate_fill(0, 0), gate_fill(127, 0), 1'b0};
        rows[1] = rows[0];
        rows[2] = {fill_vec(127), fill_vec(127), gate_fill(127, 127), gate_fill(127, 127),
                   gate_fill(127, 127), gate_fill(127, 127), 1'b0};
        // second pass drives c past 127
        rows[3] = rows[2];
        rows[4] = {fill_vec(127), fill_vec(127), gate_fill(127, 127), gate_fill(-128, -128),
                   gate_fill(127, 127), gate_fill(127, 127), 1'b1};
        names[0] = "repeat_a";
        names[1] = "repeat_b";
        names[2] = "sat_pos";
        names[3] = "sat_c";
        names[4] = "sat_neg";
        for (int i = n_fixed; i < n_rows; i++) begin
            rows[i].x        = rand_vec();
            rows[i].y_prev   = rand_vec();
            rows[i].w_i.w    = rand_vec();
            rows[i].w_i.r    = rand_vec();
            rows[i].w_z.w    = rand_vec();
            rows[i].w_z.r    = rand_vec();
            rows[i].w_f.w    = rand_vec();
            rows[i].w_f.r    = rand_vec();
            rows[i].w_o.w    = rand_vec();
            rows[i].w_o.r    = rand_vec();
            b                = rand_bits(1);
            rows[i].change_in = b[0];
            names[i]         = $sformatf("random_%0d", i);
        end
    endtask

    task automatic run_row(input int r);
        row_t                  row;
        lstm_pkg::acc_t        pre_g [4];
        lstm_pkg::data_t       act_g [4];
        lstm_pkg::data_t       exp_arg [5];
        lstm_pkg::lookup_sel_e exp_sel [5];
        lstm_pkg::data_t       c_new;
        lstm_pkg::data_t       y_exp;
        lstm_pkg::lookup_req_t got [$];
        int                    cyc;
        bit                    seen;
        row = rows[r];
        pre_g[0] = model_pre(row.x, row.y_prev, row.w_i);
        pre_g[1] = model_pre(row.x, row.y_prev, row.w_z);
        pre_g[2] = model_pre(row.x, row.y_prev, row.w_f);
        pre_g[3] = model_pre(row.x, row.y_prev, row.w_o);
        for (int g = 0; g < 4; g++) begin
            exp_arg[g] = model_gate_arg(pre_g[g], pre_shift);
            act_g[g]   = model_respond(exp_arg[g]);
        end
        c_new      = model_cell(act_g[2], c_model, act_g[0], act_g[1], frac_bits);
        exp_arg[4] = c_new;
        y_exp      = model_y(act_g[3], model_respond(c_new), frac_bits);
        c_model    = c_new;
        exp_sel[0] = lstm_pkg::sel_i;
        exp_sel[1] = lstm_pkg::sel_z;
        exp_sel[2] = lstm_pkg::sel_f;
        exp_sel[3] = lstm_pkg::sel_o;
        exp_sel[4] = lstm_pkg::sel_c;

        @(posedge clk);
        start  <= 1'b1;
        x      <= row.x;
        y_prev <= row.y_prev;
        w_i    <= row.w_i;
        w_z    <= row.w_z;
        w_f    <= row.w_f;
        w_o    <= row.w_o;
        // start edge E0
        @(posedge clk);
        start <= 1'b0;
        if (row.change_in) begin
            x      <= ~row.x;
            y_prev <= row.w_i.w;
            w_i    <= row.w_o;
            w_z    <= row.w_f;
            w_f    <= row.w_z;
            w_o    <= row.w_i;
        end
        // cyc counts rising edges after E0
        cyc  = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (act_req.req) begin
                got.push_back(act_req);
            end
            if (valid) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                cyc++;
                // stray start while busy
                start <= row.change_in && (cyc == 3);
            end
        end
        check({names[r], " valid_cycle"}, 10, cyc);
        check({names[r], " y"}, y_exp, y);
        check({names[r], " lookup_count"}, 5, got.size());
        for (int i = 0; i < 5; i++) begin
            check($sformatf("%s sel_%0d", names[r], i), int'(exp_sel[i]), int'(got[i].sel));
            check($sformatf("%s arg_%0d", names[r], i), exp_arg[i], got[i].arg);
        end
        repeat (idle_checks) begin
            @(negedge clk);
            check({names[r], " idle_valid"}, 0, valid);
            check({names[r], " idle_req"}, 0, act_req.req);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        x          = '0;
        y_prev     = '0;
        w_i        = '0;
        w_z        = '0;
        w_f        = '0;
        w_o        = '0;
        lfsr_state = 32'h502dc17f;
        c_model    = '0;
        last_y     = '0;
        build_table();
        repeat (reset_cycles - 1) @(posedge clk);
        @(negedge clk);
        check("reset valid", 0, valid);
        check("reset req", 0, act_req.req);
        check("reset y", 0, y);
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("post_reset valid", 0, valid);
        check("post_reset req", 0, act_req.req);
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
            if (r == 1 && y == last_y) begin
                $display("repeated run gave the same output, cell state was not carried");
                $display("Errors found");
                $fatal(1);
            end
            last_y = y;
        end
        $display("No errors");
        $finish;
    end

endmodule

// ==== lstm_cell.f ====
+incdir+include
logic/lstm_pkg.sv
logic/cell_sequencer.sv
logic/gate_dot.sv
logic/activation_port.sv
logic/cell_update.sv
logic/lstm_cell_top.sv
bench/lstm_cell_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module lstm_cell_tb -f lstm_cell.f

status=0
output=$(./obj_dir/Vlstm_cell_tb 2>&1) || status=$?
echo "$output"

if grep -qx "No errors" <<< "$output"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed (exit status ${status})"
    exit 1
fi
